// ==== hw/dfpPkg.sv ====
// Shared constants for the decimal32 DPD unpacker
// Field widths of the packed word, declet count and the special
// combination-field codes that mark infinity and NaN

package dfpPkg;

  // ====================
  // Packed operand layout
  // ====================

  // Whole decimal32 word: sign, combination, exponent continuation, declets
  localparam int WordWidth = 32;

  // Combination field sits just below the sign bit
  localparam int ComboWidth = 5;

  // Exponent continuation follows the combination field
  localparam int ExpContWidth = 6;

  // Biased exponent after the two high bits are pulled out of the combo field
  localparam int ExpWidth = 8;

  // ====================
  // Coefficient layout
  // ====================

  // Trailing coefficient is made of this many 10-bit declets
  localparam int NumDeclets = 2;

  // One declet packs three decimal digits
  localparam int DecletWidth = 10;

  // Every unpacked digit is plain BCD
  localparam int DigitWidth = 4;

  // Three digits per declet plus the leading digit from the combo field,
  // which gives seven BCD digits for decimal32
  localparam int SigWidth = DigitWidth * (3 * NumDeclets + 1);

  // ====================
  // Special values
  // ====================

  // All ones in the combination field marks a NaN of either kind
  localparam logic [ComboWidth-1:0] ComboNan = 5'b11111;

  // Infinity keeps the low combo bit clear
  localparam logic [ComboWidth-1:0] ComboInf = 5'b11110;

endpackage

// ==== hw/dfpComboDecode.sv ====
// Stage 1 of the unpacker
// Splits the packed decimal32 word, interprets the combination field
// and registers sign, exponent, leading digit, class flags and declets

`timescale 1ns/100ps

module dfpComboDecode (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         inValid,
  input  logic [dfpPkg::WordWidth-1:0]                 inWord,
  output logic                                         s1Valid,
  output logic                                         s1Sign,
  output logic [dfpPkg::ExpWidth-1:0]                  s1Exp,
  output logic [dfpPkg::DigitWidth-1:0]                s1Lead,
  output logic                                         s1Nan,
  output logic                                         s1Qnan,
  output logic                                         s1Snan,
  output logic                                         s1Inf,
  output logic [dfpPkg::NumDeclets*dfpPkg::DecletWidth-1:0] s1Declets
);

  import dfpPkg::*;

  // ====================
  // Field split
  // ====================

  logic                                  sign;
  logic [ComboWidth-1:0]                 combo;
  logic [ExpContWidth-1:0]               expCont;
  logic [NumDeclets*DecletWidth-1:0]     declets;
  logic                                  largeLead;

  // Sign is the top bit, then the combination field, then the exponent
  // continuation, and the declets fill the rest down to bit 0
  assign sign    = inWord[WordWidth-1];
  assign combo   = inWord[WordWidth-2 -: ComboWidth];
  assign expCont = inWord[WordWidth-2-ComboWidth -: ExpContWidth];
  assign declets = inWord[NumDeclets*DecletWidth-1:0];

  // Combo bits 4:3 both set means the leading digit is 8 or 9 and the
  // exponent high bits move down to combo bits 2:1
  assign largeLead = (combo[4:3] == 2'b11);

  // ====================
  // Stage 1 register
  // ====================

  // Valid strobe follows the input one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
    end
  end

  // Payload loads with the strobe and holds between operands
  always_ff @(posedge clk) begin
    if (inValid) begin
      s1Sign    <= sign;
      s1Exp     <= {(largeLead ? combo[2:1] : combo[4:3]), expCont};
      // Large leading digit keeps only its low bit in the combo field
      s1Lead    <= largeLead ? {3'b100, combo[0]} : {1'b0, combo[2:0]};
      s1Nan     <= (combo == ComboNan);
      // Top continuation bit tells a signalling NaN from a quiet one
      s1Snan    <= (combo == ComboNan) && expCont[ExpContWidth-1];
      s1Qnan    <= (combo == ComboNan) && !expCont[ExpContWidth-1];
      s1Inf     <= (combo == ComboInf);
      s1Declets <= declets;
    end
  end

  // A strobed operand must be fully driven, otherwise the flags and
  // digits downstream turn to X three cycles later
  inWordKnown: assert property (@(posedge clk) disable iff (reset)
    inValid |-> !$isunknown(inWord));

endmodule

// ==== hw/dpdDecletDecode.sv ====
// Stage 2 lane of the unpacker
// Turns one 10-bit densely packed decimal declet into three registered
// BCD digits, hundreds digit in the top nibble

`timescale 1ns/100ps

module dpdDecletDecode (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              decValid,
  input  logic [dfpPkg::DecletWidth-1:0]    declet,
  output logic                              digitsValid,
  output logic [3*dfpPkg::DigitWidth-1:0]   digits
);

  import dfpPkg::*;

  // ====================
  // DPD to BCD mapping
  // ====================

  logic [DigitWidth-1:0] hundreds;
  logic [DigitWidth-1:0] tens;
  logic [DigitWidth-1:0] units;

  // Bit 3 clear means all three digits are 0 to 7 and sit in plain
  // three-bit groups. Bit 3 set picks a large-digit case by bits 2:1,
  // and bits 6:5 break the tie when two or three digits are large.
  // A large digit is 8 or 9, so only its low bit is carried in the declet
  always_comb begin
    hundreds = {1'b0, declet[9:7]};
    tens     = {1'b0, declet[6:4]};
    units    = {1'b0, declet[2:0]};
    if (declet[3]) begin
      case (declet[2:1])
        // Units digit large
        2'b00: begin
          units = {3'b100, declet[0]};
        end
        // Tens digit large, its small bits move into the units slot
        2'b01: begin
          tens  = {3'b100, declet[4]};
          units = {1'b0, declet[6:5], declet[0]};
        end
        // Hundreds digit large, its small bits move into the units slot
        2'b10: begin
          hundreds = {3'b100, declet[7]};
          units    = {1'b0, declet[9:8], declet[0]};
        end
        default: begin
          case (declet[6:5])
            // Hundreds and tens large
            2'b00: begin
              hundreds = {3'b100, declet[7]};
              tens     = {3'b100, declet[4]};
              units    = {1'b0, declet[9:8], declet[0]};
            end
            // Hundreds and units large
            2'b01: begin
              hundreds = {3'b100, declet[7]};
              tens     = {1'b0, declet[9:8], declet[4]};
              units    = {3'b100, declet[0]};
            end
            // Tens and units large
            2'b10: begin
              tens  = {3'b100, declet[4]};
              units = {3'b100, declet[0]};
            end
            // All three large. Bits 9:8 are don't-care in this pattern
            default: begin
              hundreds = {3'b100, declet[7]};
              tens     = {3'b100, declet[4]};
              units    = {3'b100, declet[0]};
            end
          endcase
        end
      endcase
    end
  end

  // ====================
  // Lane register
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      digitsValid <= 1'b0;
    end else begin
      digitsValid <= decValid;
    end
  end

  // Digits load with the strobe and hold otherwise
  always_ff @(posedge clk) begin
    if (decValid) begin
      digits <= {hundreds, tens, units};
    end
  end

  // Any declet, canonical or not, must decode to valid BCD
  digitsAreBcd: assert property (@(posedge clk) disable iff (reset)
    decValid |=> (digits[11:8] <= 4'd9) && (digits[7:4] <= 4'd9)
                 && (digits[3:0] <= 4'd9));

endmodule

// ==== hw/dfpUnpackAssemble.sv ====
// Stage 3 of the unpacker
// Lines the stage-1 fields up with the lane digits, builds the seven-digit
// BCD coefficient and registers the complete unpacked result

`timescale 1ns/100ps

module dfpUnpackAssemble (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           laneValid,
  input  logic [dfpPkg::NumDeclets*3*dfpPkg::DigitWidth-1:0] laneDigits,
  input  logic                                           s1Sign,
  input  logic [dfpPkg::ExpWidth-1:0]                    s1Exp,
  input  logic [dfpPkg::DigitWidth-1:0]                  s1Lead,
  input  logic                                           s1Nan,
  input  logic                                           s1Qnan,
  input  logic                                           s1Snan,
  input  logic                                           s1Inf,
  output logic                                           outValid,
  output logic                                           outSign,
  output logic [dfpPkg::ExpWidth-1:0]                    outExp,
  output logic [dfpPkg::SigWidth-1:0]                    outSig,
  output logic                                           outNan,
  output logic                                           outQnan,
  output logic                                           outSnan,
  output logic                                           outInf
);

  import dfpPkg::*;

  // ====================
  // Stage 2 pass-through
  // ====================

  logic                  s2Sign;
  logic [ExpWidth-1:0]   s2Exp;
  logic [DigitWidth-1:0] s2Lead;
  logic                  s2Nan;
  logic                  s2Qnan;
  logic                  s2Snan;
  logic                  s2Inf;

  // Stage-1 fields already hold between operands, so a plain one-cycle
  // delay keeps them aligned with whatever the lanes captured
  always_ff @(posedge clk) begin
    s2Sign <= s1Sign;
    s2Exp  <= s1Exp;
    s2Lead <= s1Lead;
    s2Nan  <= s1Nan;
    s2Qnan <= s1Qnan;
    s2Snan <= s1Snan;
    s2Inf  <= s1Inf;
  end

  // ====================
  // Output register
  // ====================

  // Coefficient runs leading digit first, then the higher lane down to lane 0
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      outSign  <= 1'b0;
      outExp   <= '0;
      outSig   <= '0;
      outNan   <= 1'b0;
      outQnan  <= 1'b0;
      outSnan  <= 1'b0;
      outInf   <= 1'b0;
    end else begin
      outValid <= laneValid;
      if (laneValid) begin
        outSign <= s2Sign;
        outExp  <= s2Exp;
        outSig  <= {s2Lead, laneDigits};
        outNan  <= s2Nan;
        outQnan <= s2Qnan;
        outSnan <= s2Snan;
        outInf  <= s2Inf;
      end
    end
  end

  // NaN kind flags come from stage 1 two cycles earlier and must stay
  // exclusive and consistent with the NaN flag after the delay
  outNanKinds: assert property (@(posedge clk) disable iff (reset)
    !(outQnan && outSnan) && (!(outQnan || outSnan) || outNan));

endmodule

// ==== hw/dfpUnpack32.sv ====
// Top level of the decimal32 DPD unpacker
// Combination-field decoder, one declet lane per declet and the assembler,
// three register stages with a plain valid strobe

`timescale 1ns/100ps

module dfpUnpack32 (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           inValid,
  input  logic [dfpPkg::WordWidth-1:0]   inWord,
  output logic                           outValid,
  output logic                           outSign,
  output logic [dfpPkg::ExpWidth-1:0]    outExp,
  output logic [dfpPkg::SigWidth-1:0]    outSig,
  output logic                           outNan,
  output logic                           outQnan,
  output logic                           outSnan,
  output logic                           outInf
);

  import dfpPkg::*;

  // Stage 1 results
  logic                              s1Valid;
  logic                              s1Sign;
  logic [ExpWidth-1:0]               s1Exp;
  logic [DigitWidth-1:0]             s1Lead;
  logic                              s1Nan;
  logic                              s1Qnan;
  logic                              s1Snan;
  logic                              s1Inf;
  logic [NumDeclets*DecletWidth-1:0] s1Declets;

  // Stage 2 lane results with lane 0 in the low bits
  logic [NumDeclets-1:0]              laneValid;
  logic [NumDeclets*3*DigitWidth-1:0] laneDigits;

  dfpComboDecode comboDecode (
    .clk       (clk),
    .reset     (reset),
    .inValid   (inValid),
    .inWord    (inWord),
    .s1Valid   (s1Valid),
    .s1Sign    (s1Sign),
    .s1Exp     (s1Exp),
    .s1Lead    (s1Lead),
    .s1Nan     (s1Nan),
    .s1Qnan    (s1Qnan),
    .s1Snan    (s1Snan),
    .s1Inf     (s1Inf),
    .s1Declets (s1Declets)
  );

  // ====================
  // Declet lanes
  // ====================

  for (genvar lane = 0; lane < NumDeclets; lane++) begin : gLane
    dpdDecletDecode decletDecode (
      .clk         (clk),
      .reset       (reset),
      .decValid    (s1Valid),
      .declet      (s1Declets[lane*DecletWidth +: DecletWidth]),
      .digitsValid (laneValid[lane]),
      .digits      (laneDigits[lane*3*DigitWidth +: 3*DigitWidth])
    );
  end

  dfpUnpackAssemble assemble (
    .clk        (clk),
    .reset      (reset),
    .laneValid  (laneValid[0]),
    .laneDigits (laneDigits),
    .s1Sign     (s1Sign),
    .s1Exp      (s1Exp),
    .s1Lead     (s1Lead),
    .s1Nan      (s1Nan),
    .s1Qnan     (s1Qnan),
    .s1Snan     (s1Snan),
    .s1Inf      (s1Inf),
    .outValid   (outValid),
    .outSign    (outSign),
    .outExp     (outExp),
    .outSig     (outSig),
    .outNan     (outNan),
    .outQnan    (outQnan),
    .outSnan    (outSnan),
    .outInf     (outInf)
  );

endmodule

// ==== bench/dfpRefModel.svh ====
// Reference model for the decimal32 unpacker testbench
// BCD-to-DPD encoding, operand packing and the expected unpacked fields
`ifndef DFP_REF_MODEL_SVH
`define DFP_REF_MODEL_SVH

// Operand classes picked by the stimulus
localparam logic [1:0] ClsFinite = 2'd0;
localparam logic [1:0] ClsInf    = 2'd1;
localparam logic [1:0] ClsQnan   = 2'd2;
localparam logic [1:0] ClsSnan   = 2'd3;

// Canonical declet for three BCD digits, hundreds digit in the top nibble.
// The case index marks which digits are large (8 or 9)
function automatic logic [9:0] dpdEncode(input logic [11:0] bcd);
  logic [3:0] a;
  logic [3:0] b;
  logic [3:0] c;
  a = bcd[11:8];
  b = bcd[7:4];
  c = bcd[3:0];
  case ({a[3], b[3], c[3]})
    3'b000: return {a[2:0], b[2:0], 1'b0, c[2:0]};
    3'b001: return {a[2:0], b[2:0], 3'b100, c[0]};
    3'b010: return {a[2:0], c[2:1], b[0], 3'b101, c[0]};
    3'b100: return {c[2:1], a[0], b[2:0], 3'b110, c[0]};
    3'b110: return {c[2:1], a[0], 2'b00, b[0], 3'b111, c[0]};
    3'b101: return {b[2:1], a[0], 2'b01, b[0], 3'b111, c[0]};
    3'b011: return {a[2:0], 2'b10, b[0], 3'b111, c[0]};
    default: return {2'b00, a[0], 2'b11, b[0], 3'b111, c[0]};
  endcase
endfunction

// Builds the 32-bit word. For NaN the class forces the top continuation bit
function automatic logic [31:0] packOperand(input logic sign, input logic [7:0] exp,
                                            input logic [27:0] coef, input logic [1:0] cls);
  logic [4:0] combo;
  logic [5:0] cont;
  logic [3:0] lead;
  lead = coef[27:24];
  cont = exp[5:0];
  if (cls == ClsInf) begin
    combo = ComboInf;
  end else if (cls == ClsFinite) begin
    // Digits 8 and 9 push the exponent high bits down by two places
    combo = (lead < 4'd8) ? {exp[7:6], lead[2:0]} : {2'b11, exp[7:6], lead[0]};
  end else begin
    combo = ComboNan;
    cont[5] = (cls == ClsSnan);
  end
  return {sign, combo, cont, dpdEncode(coef[23:12]), dpdEncode(coef[11:0])};
endfunction

// Expected result as {sign, exp, sig, nan, qnan, snan, inf}, 41 bits.
// Specials read the combo field as a large leading digit, 8 for infinity and 9 for NaN
function automatic logic [40:0] expectFields(input logic sign, input logic [7:0] exp,
                                             input logic [27:0] coef, input logic [1:0] cls);
  logic [7:0]  e;
  logic [27:0] sig;
  logic [3:0]  flags;
  e     = exp;
  sig   = coef;
  flags = 4'b0000;
  case (cls)
    ClsInf: begin
      e     = {2'b11, exp[5:0]};
      sig   = {4'd8, coef[23:0]};
      flags = 4'b0001;
    end
    ClsQnan: begin
      e     = {3'b110, exp[4:0]};
      sig   = {4'd9, coef[23:0]};
      flags = 4'b1100;
    end
    ClsSnan: begin
      e     = {3'b111, exp[4:0]};
      sig   = {4'd9, coef[23:0]};
      flags = 4'b1010;
    end
    default: begin
      flags = 4'b0000;
    end
  endcase
  return {sign, e, sig, flags};
endfunction

`endif

// ==== bench/dfpUnpackTb.sv ====
// Testbench for the decimal32 DPD unpacker
// Clock, reset, random and directed stimulus, expected-result queue,
// result comparison, latency check and cycle-limit watchdog

`timescale 1ns/100ps

module dfpUnpackTb;

  import dfpPkg::*;

  `include "dfpRefModel.svh"

  localparam int NumDirected = 12;
  localparam int NumSweep    = 2000;
  localparam int NumRandom   = 300;
  localparam int TotalOps    = NumDirected + NumSweep + NumRandom;
  localparam int CycleLimit  = TotalOps * 2 + 100;

  logic                 clk;
  logic                 reset;
  logic                 inValid;
  logic [WordWidth-1:0] inWord;
  logic                 outValid;
  logic                 outSign;
  logic [ExpWidth-1:0]  outExp;
  logic [SigWidth-1:0]  outSig;
  logic                 outNan;
  logic                 outQnan;
  logic                 outSnan;
  logic                 outInf;

  logic [31:0] rngState;
  logic [40:0] expectQ[$];
  int          dueQ[$];
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  int          monCycle = 0;

  dfpUnpack32 UUT (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .inWord   (inWord),
    .outValid (outValid),
    .outSign  (outSign),
    .outExp   (outExp),
    .outSig   (outSig),
    .outNan   (outNan),
    .outQnan  (outQnan),
    .outSnan  (outSnan),
    .outInf   (outInf)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // ====================
  // Helpers
  // ====================

  // Linear congruential generator that returns the upper half of its state
  function automatic int unsigned nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[31:16];
  endfunction

  // Seven random decimal digits
  function automatic logic [27:0] randomCoef();
    logic [27:0] coef;
    for (int i = 0; i < 7; i++) begin
      coef[4*i +: 4] = 4'(nextRandom() % 10);
    end
    return coef;
  endfunction

  function automatic logic [11:0] tripletBcd(input int value);
    return {4'(value / 100), 4'((value / 10) % 10), 4'(value % 10)};
  endfunction

  // Drives one operand for one cycle and queues its expected result
  task automatic sendOperand(input logic sign, input logic [7:0] exp,
                             input logic [27:0] coef, input logic [1:0] cls);
    inValid = 1'b1;
    inWord  = packOperand(sign, exp, coef, cls);
    expectQ.push_back(expectFields(sign, exp, coef, cls));
    @(posedge clk);
    #2;
    inValid = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic reportMismatch(input string field, input logic [27:0] got,
                                input logic [27:0] want);
    errorCount++;
    $display("ERR %0t: %s is %0h, expected %0h", $time, field, got, want);
  endtask

  task automatic compareResult(input logic [40:0] want);
    checkCount++;
    assert (outSign == want[40]) else reportMismatch("sign", outSign, want[40]);
    assert (outExp == want[39:32]) else reportMismatch("exponent", outExp, want[39:32]);
    assert (outSig == want[31:4]) else reportMismatch("coefficient", outSig, want[31:4]);
    // Flags in the order nan, qnan, snan, inf
    assert ({outNan, outQnan, outSnan, outInf} == want[3:0])
      else reportMismatch("class flags", {outNan, outQnan, outSnan, outInf}, want[3:0]);
  endtask

  // ====================
  // Result monitor
  // ====================

  // Sampled on the falling edge where inputs and outputs are both settled.
  // An operand seen here is due at the output three falling edges later
  always @(negedge clk) begin : monitor
    logic dueNow;
    monCycle++;
    dueNow = (dueQ.size() != 0) && (dueQ[0] == monCycle);
    if (reset) begin
      // Reset clears the strobe and every output field
      assert (!outValid && !outSign && outExp == '0 && outSig == '0
              && !outNan && !outQnan && !outSnan && !outInf) else begin
        errorCount++;
        $display("ERR %0t: outputs not cleared during reset", $time);
      end
    end else begin
      if (outValid) begin
        assert (dueNow && expectQ.size() != 0) else begin
          errorCount++;
          $display("outValid high at %0t with no operand due in this cycle", $time);
        end
        if (dueNow && expectQ.size() != 0) begin
          compareResult(expectQ.pop_front());
        end
      end else begin
        assert (!dueNow) else begin
          errorCount++;
          $display("Result missing at %0t, outValid low 3 cycles after inValid", $time);
        end
        // Drop the lost result so later ones stay aligned
        if (dueNow && expectQ.size() != 0) begin
          void'(expectQ.pop_front());
        end
      end
      if (dueNow) begin
        void'(dueQ.pop_front());
      end
      if (inValid) begin
        dueQ.push_back(monCycle + 3);
      end
    end
  end

  // Watchdog on the total cycle count
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles with %0d results still pending",
               cycleCount, expectQ.size());
      $display("Verification failed");
      $finish;
    end
  end

  // ====================
  // Stimulus
  // ====================

  initial begin : stimulus
    logic [27:0] coef;
    logic [1:0]  cls;
    clk      = 1'b0;
    reset    = 1'b1;
    inValid  = 1'b0;
    inWord   = '0;
    rngState = 32'd1164;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    idleCycles(3);

    // The NaN kind of a special follows the class and not the given exponent bit
    sendOperand(1'b0, 8'h00, randomCoef(), ClsInf);
    sendOperand(1'b1, 8'h3f, randomCoef(), ClsInf);
    sendOperand(1'b0, 8'h3f, randomCoef(), ClsQnan);
    sendOperand(1'b1, 8'h00, randomCoef(), ClsQnan);
    sendOperand(1'b0, 8'h00, randomCoef(), ClsSnan);
    sendOperand(1'b1, 8'h1f, randomCoef(), ClsSnan);
    idleCycles(2);

    // Finite corners for small and large leading digits
    sendOperand(1'b0, 8'd0, 28'h0000000, ClsFinite);
    sendOperand(1'b1, 8'd191, 28'h9999999, ClsFinite);
    sendOperand(1'b0, 8'd128, 28'h8000000, ClsFinite);
    sendOperand(1'b1, 8'd64, 28'h7654321, ClsFinite);
    sendOperand(1'b0, 8'd101, 28'h9876543, ClsFinite);
    sendOperand(1'b1, 8'd190, 28'h1234567, ClsFinite);
    idleCycles(2);

    // Every triplet through lane 0 and then lane 1, back to back
    for (int t = 0; t < NumSweep; t++) begin
      coef = randomCoef();
      if (t < 1000) begin
        coef[11:0] = tripletBcd(t);
      end else begin
        coef[23:12] = tripletBcd(t - 1000);
      end
      sendOperand(1'(nextRandom()), 8'(nextRandom() % 192), coef, ClsFinite);
    end

    // Random operands, roughly one in sixteen special, with random gaps
    for (int i = 0; i < NumRandom; i++) begin
      cls = ClsFinite;
      if (nextRandom() % 16 == 0) begin
        cls = 2'(1 + nextRandom() % 3);
      end
      sendOperand(1'(nextRandom()), 8'(nextRandom() % 192), randomCoef(), cls);
      if (nextRandom() % 4 == 0) begin
        idleCycles(1 + nextRandom() % 3);
      end
    end

    // Drain the pipeline and watch a few idle cycles
    while (expectQ.size() != 0) begin
      @(posedge clk);
    end
    idleCycles(5);
    assert (dueQ.size() == 0) else begin
      errorCount++;
      $display("%0d operands never produced a result", dueQ.size());
    end

    $display("Checked %0d results, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+bench
hw/dfpPkg.sv
hw/dfpComboDecode.sv
hw/dpdDecletDecode.sv
hw/dfpUnpackAssemble.sv
hw/dfpUnpack32.sv
bench/dfpUnpackTb.sv
